// ==== logic/i2c_pkg.sv ====
// I2C bus types and timing
package i2c_pkg;

    // System clock and bus clock defaults
    localparam int I2C_CLK_HZ = 100_000_000;
    localparam int I2C_BUS_HZ = 100_000;

    localparam logic I2C_WRITE = 1'b0; // R/W bit of a write

    typedef logic [6:0] i2c_addr_t;
    typedef logic [7:0] i2c_byte_t;

    // Latched by the master when ena is seen
    typedef struct packed {
        i2c_addr_t addr;
        i2c_byte_t data;
    } i2c_req_t;

endpackage

// ==== logic/lcd_pkg.sv ====
// LCD bring-up definitions
package lcd_pkg;

    import i2c_pkg::*;

    // Delay defaults in system clocks
    localparam int LCD_POWER_UP_CYCLES   = 50_000_000;
    localparam int LCD_PROBE_WAIT_CYCLES = 10_000_000;
    localparam int LCD_CMD_SETTLE_CYCLES = 500_000;

    localparam int LCD_INIT_COUNT = 7;
    localparam logic [0:LCD_INIT_COUNT-1][7:0] LCD_INIT_CMDS = {
        8'h33, 8'h32, 8'h28, 8'h0C, 8'h06, 8'h01, 8'h80
    };
    localparam logic [7:0] LCD_LINE2_CMD = 8'hC0;

    // Two lines of 16 characters
    localparam logic [0:31][7:0] LCD_MESSAGE = "Hello from FPGA!Addr: 0x??      ";
    localparam int LCD_ADDR_HI_POS = 24;
    localparam int LCD_ADDR_LO_POS = 25;

    localparam logic [0:2][6:0] LCD_SCAN_ADDRS = {7'h20, 7'h27, 7'h3F};

    // Expander port bits, RW on bit 1 stays low
    localparam int LCD_BIT_RS = 0;
    localparam int LCD_BIT_EN = 2;
    localparam int LCD_BIT_BL = 3;

    typedef struct packed {
        logic      raw;      // Send byte as is
        logic      rs;
        i2c_byte_t data_byte;
    } lcd_xfer_t;

    typedef enum logic [1:0] {
        SCAN  = 2'd0,
        INIT  = 2'd1,
        WRITE = 2'd2,
        DONE  = 2'd3
    } bring_up_state_t;

    // Bit layout matches the board LEDs, state in the low bits
    typedef struct packed {
        logic            ack_error;
        logic            busy;
        logic            prev_busy;
        logic            ena;
        i2c_addr_t       addr;
        logic            found;
        logic [1:0]      scan_idx;
        bring_up_state_t state;
    } lcd_status_t;

endpackage

// ==== logic/i2c_byte_master.sv ====
// Write-only I2C byte master
`timescale 1ns/1ns

module i2c_byte_master
    import i2c_pkg::*;
#(
    parameter int CLK_HZ = I2C_CLK_HZ,
    parameter int BUS_HZ = I2C_BUS_HZ
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     ena,
    input  i2c_req_t req,
    output logic     busy,
    output logic     ack_error,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    localparam int DIV = (CLK_HZ / BUS_HZ) / 4;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    typedef enum logic [2:0] {
        READY, START, COMMAND, SLV_ACK1, WR, SLV_ACK2, STOP
    } master_state_t;

    master_state_t state;
    logic [CW-1:0] count;
    logic          scl_clk;
    logic          scl_ena;
    logic [2:0]    bit_cnt;
    i2c_req_t      req_q;
    logic [7:0]    frame;
    logic          tick;
    logic          fall_tick;
    logic          rise_tick;

    assign tick      = (count == CW'(DIV - 1));
    assign fall_tick = tick & scl_clk;
    assign rise_tick = tick & ~scl_clk;
    assign frame     = {req_q.addr, I2C_WRITE};
    assign scl       = scl_ena ? scl_clk : 1'b1; // Parked high when idle

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count   <= '0;
            scl_clk <= 1'b1;
        end else if (tick) begin
            count   <= '0;
            scl_clk <= ~scl_clk;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fall_tick && state == READY && ena)
            req_q <= req;
    end

    // SDA moves only on SCL falls, or with SCL parked at START and STOP
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= READY;
            busy      <= 1'b0;
            scl_ena   <= 1'b0;
            sda_oe    <= 1'b0;
            ack_error <= 1'b0;
            bit_cnt   <= 3'd7;
        end else if (rise_tick) begin
            if (state == SLV_ACK1)
                ack_error <= sda_in; // High means no ACK
        end else if (fall_tick) begin
            case (state)
                READY: begin
                    if (ena) begin
                        busy      <= 1'b1;
                        sda_oe    <= 1'b1; // START
                        ack_error <= 1'b0;
                        state     <= START;
                    end
                end
                START: begin
                    scl_ena <= 1'b1;
                    sda_oe  <= ~frame[7];
                    bit_cnt <= 3'd7;
                    state   <= COMMAND;
                end
                COMMAND: begin
                    if (bit_cnt == 3'd0) begin
                        sda_oe <= 1'b0;
                        state  <= SLV_ACK1;
                    end else begin
                        sda_oe  <= ~frame[bit_cnt - 3'd1];
                        bit_cnt <= bit_cnt - 3'd1;
                    end
                end
                SLV_ACK1: begin
                    sda_oe  <= ~req_q.data[7];
                    bit_cnt <= 3'd7;
                    state   <= WR;
                end
                WR: begin
                    if (bit_cnt == 3'd0) begin
                        sda_oe <= 1'b0;
                        state  <= SLV_ACK2;
                    end else begin
                        sda_oe  <= ~req_q.data[bit_cnt - 3'd1];
                        bit_cnt <= bit_cnt - 3'd1;
                    end
                end
                SLV_ACK2: begin
                    sda_oe <= 1'b1; // Low ahead of STOP
                    state  <= STOP;
                end
                STOP: begin
                    if (scl_ena) begin
                        scl_ena <= 1'b0;
                    end else begin
                        sda_oe <= 1'b0; // SDA rises with SCL high
                        busy   <= 1'b0;
                        state  <= READY;
                    end
                end
                default: state <= READY;
            endcase
        end
    end

endmodule

// ==== logic/lcd_nibble_sender.sv ====
// LCD byte to expander writes
`timescale 1ns/1ns

module lcd_nibble_sender
    import i2c_pkg::*;
    import lcd_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      start,
    input  lcd_xfer_t xfer,
    input  i2c_addr_t addr,
    output logic      done,
    output logic      done_busy,
    output logic      i2c_ena,
    output i2c_req_t  i2c_req,
    input  logic      i2c_busy
);

    lcd_xfer_t  xfer_q;
    logic       active;
    logic       pending;
    logic       prev_busy;
    logic [1:0] phase;
    logic [3:0] nib;
    logic       busy_fall;
    logic       last_phase;

    assign nib        = phase[1] ? xfer_q.data_byte[3:0] : xfer_q.data_byte[7:4];
    assign busy_fall  = prev_busy & ~i2c_busy;
    assign last_phase = xfer_q.raw | (phase == 2'd3);
    assign done_busy  = active;

    // Phases 0..3 are high EN, high, low EN, low
    always_comb begin
        i2c_req.addr = addr;
        if (xfer_q.raw) begin
            i2c_req.data = xfer_q.data_byte;
        end else begin
            i2c_req.data             = '0;
            i2c_req.data[7:4]        = nib;
            i2c_req.data[LCD_BIT_EN] = ~phase[0];
            i2c_req.data[LCD_BIT_BL] = 1'b1;
            i2c_req.data[LCD_BIT_RS] = xfer_q.rs;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            xfer_q <= xfer;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active    <= 1'b0;
            pending   <= 1'b0;
            prev_busy <= 1'b0;
            phase     <= 2'd0;
            i2c_ena   <= 1'b0;
            done      <= 1'b0;
        end else begin
            prev_busy <= i2c_busy;
            done      <= 1'b0;
            if (start) begin
                active <= 1'b1;
                phase  <= 2'd0;
            end else if (active) begin
                if (!pending && !i2c_busy && !i2c_ena) begin
                    i2c_ena <= 1'b1;
                    pending <= 1'b1;
                end
                if (i2c_busy)
                    i2c_ena <= 1'b0;
                if (pending && busy_fall) begin
                    pending <= 1'b0;
                    if (last_phase) begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end else begin
                        phase <= phase + 2'd1;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/lcd_bring_up.sv ====
// LCD bring-up sequencer
`timescale 1ns/1ns

module lcd_bring_up
    import i2c_pkg::*;
    import lcd_pkg::*;
#(
    parameter int POWER_UP_CYCLES   = LCD_POWER_UP_CYCLES,
    parameter int PROBE_WAIT_CYCLES = LCD_PROBE_WAIT_CYCLES,
    parameter int CMD_SETTLE_CYCLES = LCD_CMD_SETTLE_CYCLES
) (
    input  logic        clk,
    input  logic        reset_n,
    output logic        start,
    output lcd_xfer_t   xfer,
    output i2c_addr_t   addr,
    input  logic        done,
    input  logic        done_busy,
    input  logic        ack_error,
    output lcd_status_t status
);

    bring_up_state_t  state;
    logic [1:0]       step;      // Delay, issue, wait, settle
    logic [31:0]      delay_cnt;
    logic [1:0]       scan_idx;
    logic [2:0]       cmd_idx;
    logic [5:0]       seq_idx;   // 16 is the line jump
    logic             found;
    logic             done_busy_q;
    logic [0:31][7:0] msg;

    function automatic logic [7:0] hex_ascii(input logic [3:0] h);
        return (h < 4'd10) ? (8'h30 + 8'(h)) : (8'h37 + 8'(h));
    endfunction

    assign addr = LCD_SCAN_ADDRS[scan_idx];

    always_comb begin
        status           = '0;
        status.state     = state;
        status.scan_idx  = scan_idx;
        status.found     = found;
        status.addr      = addr;
        status.ena       = start;
        status.prev_busy = done_busy_q;
        status.busy      = done_busy;
        status.ack_error = ack_error;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= SCAN;
            step        <= 2'd0;
            delay_cnt   <= '0;
            scan_idx    <= 2'd0;
            cmd_idx     <= 3'd0;
            seq_idx     <= 6'd0;
            found       <= 1'b0;
            start       <= 1'b0;
            xfer        <= '0;
            done_busy_q <= 1'b0;
            msg         <= LCD_MESSAGE;
        end else begin
            start       <= 1'b0;
            done_busy_q <= done_busy;
            case (step)
                2'd0: begin // Power-up wait
                    if (delay_cnt == 32'(POWER_UP_CYCLES - 1)) begin
                        delay_cnt <= '0;
                        step      <= 2'd1;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                2'd1: begin
                    if (state != DONE && !done_busy) begin
                        start <= 1'b1;
                        step  <= 2'd2;
                        case (state)
                            SCAN:    xfer <= '{raw: 1'b1, rs: 1'b0, data_byte: 8'h00};
                            INIT:    xfer <= '{raw: 1'b0, rs: 1'b0,
                                               data_byte: LCD_INIT_CMDS[cmd_idx]};
                            default: begin
                                if (seq_idx == 6'd16)
                                    xfer <= '{raw: 1'b0, rs: 1'b0, data_byte: LCD_LINE2_CMD};
                                else if (seq_idx < 6'd16)
                                    xfer <= '{raw: 1'b0, rs: 1'b1,
                                              data_byte: msg[seq_idx[4:0]]};
                                else
                                    xfer <= '{raw: 1'b0, rs: 1'b1,
                                              data_byte: msg[5'(seq_idx - 6'd1)]};
                            end
                        endcase
                    end
                end
                2'd2: begin
                    if (done) begin
                        if (state != WRITE)
                            step <= 2'd3;
                        else if (seq_idx == 6'd32)
                            state <= DONE;
                        else begin
                            seq_idx <= seq_idx + 6'd1;
                            step    <= 2'd1;
                        end
                    end
                end
                default: begin
                    if (state == SCAN) begin
                        if (delay_cnt == 32'(PROBE_WAIT_CYCLES - 1)) begin
                            delay_cnt <= '0;
                            step      <= 2'd1;
                            if (!ack_error) begin
                                found                <= 1'b1;
                                msg[LCD_ADDR_HI_POS] <= hex_ascii({1'b0, addr[6:4]});
                                msg[LCD_ADDR_LO_POS] <= hex_ascii(addr[3:0]);
                                state                <= INIT;
                                cmd_idx              <= 3'd0;
                            end else if (scan_idx < 2'd2) begin
                                scan_idx <= scan_idx + 2'd1;
                            end else begin
                                state <= DONE; // No device answered
                            end
                        end else begin
                            delay_cnt <= delay_cnt + 1'b1;
                        end
                    end else if (delay_cnt == 32'(CMD_SETTLE_CYCLES - 1)) begin
                        delay_cnt <= '0;
                        step      <= 2'd1;
                        if (cmd_idx == 3'(LCD_INIT_COUNT - 1)) begin
                            state   <= WRITE;
                            seq_idx <= 6'd0;
                        end else begin
                            cmd_idx <= cmd_idx + 3'd1;
                        end
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== logic/lcd_i2c_top.sv ====
// LCD over I2C bring-up top
`timescale 1ns/1ns

module lcd_i2c_top
    import i2c_pkg::*;
    import lcd_pkg::*;
#(
    parameter int POWER_UP_CYCLES   = LCD_POWER_UP_CYCLES,
    parameter int PROBE_WAIT_CYCLES = LCD_PROBE_WAIT_CYCLES,
    parameter int CMD_SETTLE_CYCLES = LCD_CMD_SETTLE_CYCLES,
    parameter int CLK_HZ            = I2C_CLK_HZ,
    parameter int BUS_HZ            = I2C_BUS_HZ
) (
    input  logic        clk,
    input  logic        reset_n,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in,
    output lcd_status_t led
);

    logic      start;
    logic      done;
    logic      done_busy;
    lcd_xfer_t xfer;
    i2c_addr_t addr;
    logic      i2c_ena;
    logic      i2c_busy;
    logic      ack_error;
    i2c_req_t  i2c_req;

    lcd_bring_up #(
        .POWER_UP_CYCLES  (POWER_UP_CYCLES),
        .PROBE_WAIT_CYCLES(PROBE_WAIT_CYCLES),
        .CMD_SETTLE_CYCLES(CMD_SETTLE_CYCLES)
    ) u_bring_up (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .xfer     (xfer),
        .addr     (addr),
        .done     (done),
        .done_busy(done_busy),
        .ack_error(ack_error),
        .status   (led)
    );

    lcd_nibble_sender u_sender (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .xfer     (xfer),
        .addr     (addr),
        .done     (done),
        .done_busy(done_busy),
        .i2c_ena  (i2c_ena),
        .i2c_req  (i2c_req),
        .i2c_busy (i2c_busy)
    );

    i2c_byte_master #(
        .CLK_HZ(CLK_HZ),
        .BUS_HZ(BUS_HZ)
    ) u_master (
        .clk      (clk),
        .reset_n  (reset_n),
        .ena      (i2c_ena),
        .req      (i2c_req),
        .busy     (i2c_busy),
        .ack_error(ack_error),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

// ==== bench/lcd_i2c_properties.sv ====
// I2C master bus checks
`timescale 1ns/1ns

module lcd_i2c_properties (
    input logic clk,
    input logic reset_n,
    input logic ena,
    input logic busy,
    input logic scl,
    input logic sda_oe
);

    // START and STOP move SDA on the edges where busy changes
    property sda_held_while_scl_high;
        @(posedge clk) disable iff (!reset_n)
            (scl && $past(scl) && busy && $past(busy)) |-> $stable(sda_oe);
    endproperty

    property busy_follows_ena;
        @(posedge clk) disable iff (!reset_n)
            $rose(busy) |-> $past(ena);
    endproperty

    property scl_parked_when_idle;
        @(posedge clk) disable iff (!reset_n)
            !busy |-> scl;
    endproperty

    sda_held_check: assert property (sda_held_while_scl_high)
        else $error("SDA changed while SCL was high in the middle of a transfer");
    busy_check: assert property (busy_follows_ena)
        else $error("Master went busy without ena");
    idle_scl_check: assert property (scl_parked_when_idle)
        else $error("SCL low while the master is idle");

endmodule

bind i2c_byte_master lcd_i2c_properties u_properties (
    .clk    (clk),
    .reset_n(reset_n),
    .ena    (ena),
    .busy   (busy),
    .scl    (scl),
    .sda_oe (sda_oe)
);

// ==== bench/i2c_lcd_target.sv ====
// Behavioral I2C port expander
`timescale 1ns/1ns

module i2c_lcd_target
    import i2c_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      ack_enable,
    input  i2c_addr_t ack_addr,
    input  logic      scl,
    input  logic      sda_oe,
    output logic      sda,
    output logic      addr_valid,
    output i2c_addr_t addr_seen,
    output logic      data_valid,
    output i2c_byte_t data_byte
);

    logic       pull;
    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic       addr_phase;
    logic       selected;

    assign sda = ~sda_oe & ~pull; // Wired-AND with the pull-up

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pull       <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            bit_cnt    <= 4'd0;
            shift      <= 8'h00;
            addr_phase <= 1'b0;
            selected   <= 1'b0;
            addr_valid <= 1'b0;
            addr_seen  <= '0;
            data_valid <= 1'b0;
            data_byte  <= '0;
        end else begin
            scl_q      <= scl;
            sda_q      <= sda;
            addr_valid <= 1'b0;
            data_valid <= 1'b0;
            if (scl && scl_q && sda_q && !sda) begin // START
                bit_cnt    <= 4'd0;
                addr_phase <= 1'b1;
                selected   <= 1'b0;
                pull       <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin // STOP
                bit_cnt    <= 4'd0;
                addr_phase <= 1'b0;
                selected   <= 1'b0;
                pull       <= 1'b0;
            end else if (scl && !scl_q) begin
                if (bit_cnt < 4'd8) begin
                    shift   <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7) begin
                        // Drive ACK through the ninth clock
                        if (addr_phase)
                            pull <= ack_enable && (shift[6:0] == ack_addr) && !sda;
                        else
                            pull <= selected;
                    end
                end else begin
                    pull    <= 1'b0;
                    bit_cnt <= 4'd0;
                    if (addr_phase) begin
                        addr_valid <= 1'b1;
                        addr_seen  <= shift[7:1];
                        selected   <= pull;
                        addr_phase <= 1'b0;
                    end else if (selected) begin
                        data_valid <= 1'b1;
                        data_byte  <= shift;
                    end
                end
            end
        end
    end

endmodule

// ==== bench/tb_lcd_i2c.sv ====
// LCD over I2C bring-up testbench
`timescale 1ns/1ns

module tb_lcd_i2c
    import i2c_pkg::*;
    import lcd_pkg::*;
    ();

    localparam int POWER_UP_CYCLES   = 20;
    localparam int PROBE_WAIT_CYCLES = 10;
    localparam int CMD_SETTLE_CYCLES = 5;
    localparam int CLK_HZ            = 400;
    localparam int BUS_HZ            = 100;
    localparam int SEED              = 16989;

    // Master steps once every two clocks with a divider of 1
    localparam int STEP_CLKS    = 2;
    localparam int WRITE_TICKS  = 20;
    localparam int BUS_WRITES   = 3 + (LCD_INIT_COUNT + 33) * 4;
    localparam int DELAY_CLKS   = POWER_UP_CYCLES + 3 * PROBE_WAIT_CYCLES
                                  + LCD_INIT_COUNT * CMD_SETTLE_CYCLES;
    localparam int IDLE_CLKS    = 200;
    localparam int TIMEOUT_CLKS = 2 * (BUS_WRITES * WRITE_TICKS * STEP_CLKS + DELAY_CLKS)
                                  + IDLE_CLKS;

    localparam logic [0:15][7:0] HEX_DIGITS = "0123456789ABCDEF";

    logic        clk     = 1'b0;
    logic        reset_n = 1'b0;
    logic        scl;
    logic        sda_oe;
    logic        sda;
    lcd_status_t led;

    logic      ack_enable;
    i2c_addr_t ack_addr;
    logic      addr_valid;
    i2c_addr_t addr_seen;
    logic      data_valid;
    i2c_byte_t data_byte;

    i2c_byte_t exp_bytes[$];
    i2c_byte_t got_bytes[$];
    i2c_addr_t exp_addrs[$];
    i2c_addr_t got_addrs[$];

    int dev_idx;
    int error_count   = 0;
    int check_count   = 0;
    int cycle_count   = 0;
    int idle_activity = 0;

    lcd_i2c_top #(
        .POWER_UP_CYCLES  (POWER_UP_CYCLES),
        .PROBE_WAIT_CYCLES(PROBE_WAIT_CYCLES),
        .CMD_SETTLE_CYCLES(CMD_SETTLE_CYCLES),
        .CLK_HZ           (CLK_HZ),
        .BUS_HZ           (BUS_HZ)
    ) DUT (
        .clk    (clk),
        .reset_n(reset_n),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda),
        .led    (led)
    );

    i2c_lcd_target u_target (
        .clk       (clk),
        .reset_n   (reset_n),
        .ack_enable(ack_enable),
        .ack_addr  (ack_addr),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda       (sda),
        .addr_valid(addr_valid),
        .addr_seen (addr_seen),
        .data_valid(data_valid),
        .data_byte (data_byte)
    );

    always #2 clk = ~clk;

    function automatic logic [7:0] hex_char(input logic [3:0] v);
        return HEX_DIGITS[v];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual == expected) else begin
            error_count++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    // D7..D4, BL, EN, RW, RS
    task automatic push_lcd_byte(input logic [7:0] value, input logic rs, input i2c_addr_t dev);
        exp_bytes.push_back({value[7:4], 1'b1, 1'b1, 1'b0, rs});
        exp_bytes.push_back({value[7:4], 1'b1, 1'b0, 1'b0, rs});
        exp_bytes.push_back({value[3:0], 1'b1, 1'b1, 1'b0, rs});
        exp_bytes.push_back({value[3:0], 1'b1, 1'b0, 1'b0, rs});
        repeat (4) exp_addrs.push_back(dev);
    endtask

    task automatic build_expected(input int idx);
        i2c_addr_t        dev;
        logic [0:31][7:0] text;
        text = LCD_MESSAGE;
        for (int k = 0; k <= idx && k < 3; k++)
            exp_addrs.push_back(LCD_SCAN_ADDRS[k]);
        if (idx < 3) begin
            dev = LCD_SCAN_ADDRS[idx];
            text[LCD_ADDR_HI_POS] = hex_char({1'b0, dev[6:4]});
            text[LCD_ADDR_LO_POS] = hex_char(dev[3:0]);
            exp_bytes.push_back(8'h00); // Probe byte reaches the device
            for (int k = 0; k < LCD_INIT_COUNT; k++)
                push_lcd_byte(LCD_INIT_CMDS[k], 1'b0, dev);
            for (int k = 0; k < 16; k++)
                push_lcd_byte(text[k], 1'b1, dev);
            push_lcd_byte(8'hC0, 1'b0, dev);
            for (int k = 16; k < 32; k++)
                push_lcd_byte(text[k], 1'b1, dev);
        end
    endtask

    always @(posedge clk) begin
        if (data_valid)
            got_bytes.push_back(data_byte);
        if (addr_valid)
            got_addrs.push_back(addr_seen);
    end

    always @(negedge clk) begin
        if (reset_n && led.state == DONE && (!scl || sda_oe))
            idle_activity++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CLKS) begin
            $display("Timeout after %0d cycles, bring-up or idle window never ended", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int        base;
        i2c_addr_t dev;
        void'($urandom(SEED));
        dev_idx    = int'($urandom % 32'd4);
        ack_enable = (dev_idx < 3);
        ack_addr   = (dev_idx < 3) ? LCD_SCAN_ADDRS[dev_idx] : 7'h00;
        dev        = ack_addr;
        build_expected(dev_idx);
        $display("Device index %0d, expecting %0d data bytes", dev_idx, exp_bytes.size());

        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("reset state", SCAN, led.state);
        check_value("reset found", 0, led.found);
        check_value("reset ena", 0, led.ena);
        check_value("reset busy", 0, led.busy);
        check_value("reset prev busy", 0, led.prev_busy);
        check_value("reset scan index", 0, led.scan_idx);
        check_value("reset scl", 1, scl);
        check_value("reset sda_oe", 0, sda_oe);

        while (!led.found && led.state != DONE)
            @(negedge clk);
        if (dev_idx < 3) begin
            check_value("probes before found", dev_idx + 1, got_addrs.size());
            check_value("found address", dev, led.addr);
            check_value("scan index at found", dev_idx, led.scan_idx);
        end

        while (led.state != DONE)
            @(negedge clk);
        check_value("found at done", (dev_idx < 3), led.found);
        check_value("scan index at done", (dev_idx < 3) ? dev_idx : 2, led.scan_idx);
        check_value("ack_error at done", (dev_idx == 3), led.ack_error);
        if (dev_idx < 3)
            check_value("address at done", dev, led.addr);

        repeat (IDLE_CLKS) @(negedge clk);
        check_value("bus activity after done", 0, idle_activity);
        check_value("busy after done", 0, led.busy);
        check_value("prev busy after done", 0, led.prev_busy);

        check_value("address frame count", exp_addrs.size(), got_addrs.size());
        for (int i = 0; i < exp_addrs.size() && i < got_addrs.size(); i++)
            check_value($sformatf("address frame %0d", i), exp_addrs[i], got_addrs[i]);
        check_value("data byte count", exp_bytes.size(), got_bytes.size());
        for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++)
            check_value($sformatf("data byte %0d", i), exp_bytes[i], got_bytes[i]);

        // Character 24 is sequence item 25 after the line jump
        base = 1 + LCD_INIT_COUNT * 4 + (LCD_ADDR_HI_POS + 1) * 4;
        if (dev_idx < 3 && got_bytes.size() >= base + 8) begin
            check_value("hex high digit", hex_char({1'b0, dev[6:4]}),
                        {got_bytes[base][7:4], got_bytes[base + 2][7:4]});
            check_value("hex low digit", hex_char(dev[3:0]),
                        {got_bytes[base + 4][7:4], got_bytes[base + 6][7:4]});
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== lcd_i2c.f ====
logic/i2c_pkg.sv
logic/lcd_pkg.sv
logic/i2c_byte_master.sv
logic/lcd_nibble_sender.sv
logic/lcd_bring_up.sv
logic/lcd_i2c_top.sv
bench/lcd_i2c_properties.sv
bench/i2c_lcd_target.sv
bench/tb_lcd_i2c.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_lcd_i2c
RTL_TOP    ?= lcd_i2c_top
FILELIST   ?= lcd_i2c.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert --timing
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
